/* rtl/rv64i_pkg.sv */
// Widths, opcodes, ALU operations, control and debug record types for the RV64I core
package rv64i_pkg;

    localparam int xlen      = 64;
    localparam int ilen      = 32;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0]              word_t;
    typedef logic [ilen-1:0]              instr_t;
    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;
    typedef logic [xlen/8-1:0]            strobe_t;

    localparam word_t reset_pc = '0;

    // Major opcodes, instruction bits 6..0
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg_32 = 7'b0111011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_src_t;

    // Encoded as funct3 bits 1..0
    typedef enum logic [1:0] {size_byte, size_half, size_word, size_double} mem_size_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry_out;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic      alu_a_pc;
        logic      alu_b_imm;
        alu_op_t   alu_op;
        logic      word_op;
        logic      pc_target_reg;
        wb_src_t   wb_src;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      load_unsigned;
    } control_t;

    // Retirement record for the debug port
    typedef struct packed {
        logic      enable;
        reg_addr_t destination;
        word_t     data;
    } reg_write_t;

endpackage

/* rtl/rv64i_decoder.sv */
// Instruction decoder producing the control word and the branch decision
`timescale 1ns/1ps

module rv64i_decoder (
    input  rv64i_pkg::instr_t     instruction,
    input  rv64i_pkg::alu_flags_t flags,
    output rv64i_pkg::control_t   control,
    output logic                  take_branch
);
    import rv64i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       less_signed;
    logic       branch_condition;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // funct7 bit 5 picks SUB over ADD and SRA over SRL
    function automatic alu_op_t decode_alu_op(input logic [2:0] f3, input logic alternate);
        alu_op_t result;
        case (f3)
            3'b000:  result = alternate ? alu_sub : alu_add;
            3'b001:  result = alu_sll;
            3'b010:  result = alu_slt;
            3'b011:  result = alu_sltu;
            3'b100:  result = alu_xor;
            3'b101:  result = alternate ? alu_sra : alu_srl;
            3'b110:  result = alu_or;
            default: result = alu_and;
        endcase
        return result;
    endfunction

    always_comb begin
        control        = '0;
        control.alu_op = alu_add;
        control.wb_src = wb_alu;
        case (opcode)
            op_lui: begin
                control.alu_b_imm = 1'b1;
                control.reg_write = 1'b1;
            end
            op_auipc: begin
                control.alu_a_pc  = 1'b1;
                control.alu_b_imm = 1'b1;
                control.reg_write = 1'b1;
            end
            op_jal, op_jalr: begin
                control.pc_target_reg = (opcode == op_jalr);
                control.wb_src        = wb_pc4;
                control.reg_write     = 1'b1;
            end
            op_branch: control.alu_op = alu_sub;
            op_load: begin
                control.alu_b_imm     = 1'b1;
                control.wb_src        = wb_load;
                control.reg_write     = 1'b1;
                control.mem_read      = 1'b1;
                control.mem_size      = mem_size_t'(funct3[1:0]);
                control.load_unsigned = funct3[2];
            end
            op_store: begin
                control.alu_b_imm = 1'b1;
                control.mem_write = 1'b1;
                control.mem_size  = mem_size_t'(funct3[1:0]);
            end
            op_imm: begin
                control.alu_b_imm = 1'b1;
                control.alu_op    = decode_alu_op(funct3, funct7[5] && funct3 == 3'b101);
                control.reg_write = 1'b1;
            end
            // Only ADDIW in this group
            op_imm_32: begin
                control.alu_b_imm = 1'b1;
                control.word_op   = 1'b1;
                control.reg_write = 1'b1;
            end
            op_reg: begin
                control.alu_op    = decode_alu_op(funct3, funct7[5]);
                control.reg_write = 1'b1;
            end
            op_reg_32: begin
                control.alu_op    = funct7[5] ? alu_sub : alu_add;
                control.word_op   = 1'b1;
                control.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Flags come from rs1 - rs2
    assign less_signed = flags.negative ^ flags.overflow;

    always_comb begin
        case (funct3)
            3'b000:  branch_condition = flags.zero;
            3'b001:  branch_condition = !flags.zero;
            3'b100:  branch_condition = less_signed;
            3'b101:  branch_condition = !less_signed;
            3'b110:  branch_condition = !flags.carry_out;
            3'b111:  branch_condition = flags.carry_out;
            default: branch_condition = 1'b0;
        endcase
    end

    assign take_branch = (opcode == op_jal) || (opcode == op_jalr)
                      || (opcode == op_branch && branch_condition);

    // Instruction memory must only hold encodings this core implements
    always_comb begin
        if (!$isunknown(opcode)) begin
            supported_opcode: assert (opcode inside {op_lui, op_auipc, op_jal, op_jalr,
                op_branch, op_load, op_store, op_imm, op_imm_32, op_reg, op_reg_32})
                else $error("unsupported opcode %b", opcode);
        end
    end

endmodule

/* rtl/rv64i_immediate_gen.sv */
// Immediate generator for the I, S, B, U and J formats
`timescale 1ns/1ps

module rv64i_immediate_gen (
    input  rv64i_pkg::instr_t instruction,
    output rv64i_pkg::word_t  immediate
);
    import rv64i_pkg::*;

    logic [6:0] opcode;
    logic       sign;

    assign opcode = instruction[6:0];
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            op_imm, op_imm_32, op_load, op_jalr:
                immediate = {{52{sign}}, instruction[31:20]};
            op_store:
                immediate = {{52{sign}}, instruction[31:25], instruction[11:7]};
            op_branch:
                immediate = {{51{sign}}, sign, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            op_lui, op_auipc:
                immediate = {{32{sign}}, instruction[31:12], 12'b0};
            op_jal:
                immediate = {{43{sign}}, sign, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            // R-type has no immediate
            default:
                immediate = '0;
        endcase
    end

endmodule

/* rtl/rv64i_register_file.sv */
// Integer register file with two asynchronous read ports and one write port
`timescale 1ns/1ps

module rv64i_register_file (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 write_enable,
    input  rv64i_pkg::reg_addr_t read_address1,
    input  rv64i_pkg::reg_addr_t read_address2,
    input  rv64i_pkg::reg_addr_t write_address,
    input  rv64i_pkg::word_t     write_data,
    output rv64i_pkg::word_t     read_data1,
    output rv64i_pkg::word_t     read_data2
);
    import rv64i_pkg::*;

    word_t registers [reg_count];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            registers[write_address] <= write_data;
        end
    end

    assign read_data1 = registers[read_address1];
    assign read_data2 = registers[read_address2];

    x0_stays_zero: assert property (@(posedge clock) disable iff (reset)
        registers[0] == '0)
        else $error("x0 holds %h", registers[0]);

endmodule

/* rtl/rv64i_alu.sv */
// 64-bit ALU with comparison flags taken from a - b
`timescale 1ns/1ps

module rv64i_alu (
    input  rv64i_pkg::word_t      a,
    input  rv64i_pkg::word_t      b,
    input  rv64i_pkg::alu_op_t    op,
    output rv64i_pkg::word_t      y,
    output rv64i_pkg::alu_flags_t flags
);
    import rv64i_pkg::*;

    logic [xlen:0]           difference;
    logic [$clog2(xlen)-1:0] shift_amount;
    logic                    less_signed;

    // a + ~b + 1, bit xlen is the carry out (set when a >= b unsigned)
    assign difference   = {1'b0, a} + {1'b0, ~b} + 1'b1;
    assign shift_amount = b[$clog2(xlen)-1:0];

    assign flags.zero      = (difference[xlen-1:0] == '0);
    assign flags.negative  = difference[xlen-1];
    assign flags.carry_out = difference[xlen];
    assign flags.overflow  = (a[xlen-1] != b[xlen-1])
                          && (difference[xlen-1] != a[xlen-1]);

    assign less_signed = flags.negative ^ flags.overflow;

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = difference[xlen-1:0];
            alu_sll:  y = a << shift_amount;
            alu_slt:  y = word_t'(less_signed);
            alu_sltu: y = word_t'(!flags.carry_out);
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shift_amount;
            alu_sra:  y = word_t'($signed(a) >>> shift_amount);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

/* rtl/rv64i_datapath.sv */
// Datapath with PC, operand selection, target adders, register file, ALU and write-back
`timescale 1ns/1ps

module rv64i_datapath (
    input  logic                  clock,
    input  logic                  reset,
    input  rv64i_pkg::instr_t     instruction,
    input  rv64i_pkg::word_t      immediate,
    input  rv64i_pkg::control_t   control,
    input  logic                  take_branch,
    input  rv64i_pkg::word_t      load_value,
    output rv64i_pkg::word_t      pc,
    output rv64i_pkg::word_t      alu_result,
    output rv64i_pkg::word_t      store_value,
    output rv64i_pkg::alu_flags_t flags,
    output rv64i_pkg::reg_write_t reg_write
);
    import rv64i_pkg::*;

    reg_addr_t rs1_address;
    reg_addr_t rd_address;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_y;
    word_t     pc_plus_4;
    word_t     target_sum;
    word_t     next_pc;
    word_t     write_back;

    // LUI's rs1 field holds immediate bits, read x0 instead
    assign rs1_address = (instruction[6:0] == op_lui) ? '0 : instruction[19:15];
    assign rd_address  = instruction[11:7];

    rv64i_register_file register_file0 (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (control.reg_write),
        .read_address1 (rs1_address),
        .read_address2 (instruction[24:20]),
        .write_address (rd_address),
        .write_data    (write_back),
        .read_data1    (rs1_data),
        .read_data2    (rs2_data)
    );

    assign alu_a = control.alu_a_pc  ? pc        : rs1_data;
    assign alu_b = control.alu_b_imm ? immediate : rs2_data;

    rv64i_alu alu0 (
        .a     (alu_a),
        .b     (alu_b),
        .op    (control.alu_op),
        .y     (alu_y),
        .flags (flags)
    );

    // W-suffix results keep 32 bits, sign-extended
    assign alu_result = control.word_op ? {{32{alu_y[31]}}, alu_y[31:0]} : alu_y;

    assign pc_plus_4  = pc + word_t'(4);
    assign target_sum = (control.pc_target_reg ? rs1_data : pc) + immediate;
    // JALR target has bit 0 cleared
    assign next_pc    = take_branch
                      ? {target_sum[xlen-1:1], target_sum[0] & !control.pc_target_reg}
                      : pc_plus_4;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        case (control.wb_src)
            wb_load: write_back = load_value;
            wb_pc4:  write_back = pc_plus_4;
            default: write_back = alu_result;
        endcase
    end

    assign store_value           = rs2_data;
    assign reg_write.enable      = control.reg_write && rd_address != '0;
    assign reg_write.destination = rd_address;
    assign reg_write.data        = write_back;

endmodule

/* rtl/rv64i_memory_interface.sv */
// Data memory interface for store lane alignment and load extension
`timescale 1ns/1ps

module rv64i_memory_interface (
    input  rv64i_pkg::control_t control,
    input  rv64i_pkg::word_t    address,
    input  rv64i_pkg::word_t    store_value,
    input  rv64i_pkg::word_t    read_data,
    output rv64i_pkg::word_t    write_data,
    output rv64i_pkg::strobe_t  write_strobe,
    output logic                write_enable,
    output rv64i_pkg::word_t    load_value
);
    import rv64i_pkg::*;

    logic [2:0] byte_offset;
    strobe_t    size_mask;
    word_t      shifted_read;
    word_t      extended;
    logic       sign_fill;

    assign byte_offset = address[2:0];

    always_comb begin
        case (control.mem_size)
            size_byte: size_mask = 8'h01;
            size_half: size_mask = 8'h03;
            size_word: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    // Stores move into the addressed byte lanes
    assign write_enable = control.mem_write;
    assign write_strobe = control.mem_write ? strobe_t'(size_mask << byte_offset) : '0;
    assign write_data   = store_value << {byte_offset, 3'b000};

    // Loads move the addressed lanes down to bit 0
    assign shifted_read = read_data >> {byte_offset, 3'b000};

    always_comb begin
        case (control.mem_size)
            size_byte: begin
                sign_fill = shifted_read[7] && !control.load_unsigned;
                extended  = {{56{sign_fill}}, shifted_read[7:0]};
            end
            size_half: begin
                sign_fill = shifted_read[15] && !control.load_unsigned;
                extended  = {{48{sign_fill}}, shifted_read[15:0]};
            end
            size_word: begin
                sign_fill = shifted_read[31] && !control.load_unsigned;
                extended  = {{32{sign_fill}}, shifted_read[31:0]};
            end
            default: begin
                sign_fill = 1'b0;
                extended  = shifted_read;
            end
        endcase
    end

    assign load_value = control.mem_read ? extended : '0;

    // Every strobed store keeps all lanes of its size inside the word
    always_comb begin
        if (!$isunknown(write_strobe) && write_strobe != '0) begin
            store_lanes: assert (write_enable && $countones(write_strobe) == $countones(size_mask))
                else $error("strobe %b for size %s", write_strobe, control.mem_size.name());
        end
    end

endmodule

/* rtl/rv64i_core.sv */
// Single-cycle RV64I core top level
`timescale 1ns/1ps

module rv64i_core (
    input  logic                  clock,
    input  logic                  reset,
    input  rv64i_pkg::instr_t     instruction,
    output rv64i_pkg::word_t      instruction_address,
    input  rv64i_pkg::word_t      read_data,
    output rv64i_pkg::word_t      write_data,
    output rv64i_pkg::word_t      data_address,
    output rv64i_pkg::strobe_t    write_strobe,
    output logic                  write_enable,
    output rv64i_pkg::reg_write_t db_reg_write
);
    import rv64i_pkg::*;

    control_t   control;
    alu_flags_t flags;
    logic       take_branch;
    word_t      immediate;
    word_t      alu_result;
    word_t      store_value;
    word_t      load_value;
    logic       mem_write_enable;
    reg_write_t retired;

    rv64i_decoder decoder0 (
        .instruction (instruction),
        .flags       (flags),
        .control     (control),
        .take_branch (take_branch)
    );

    rv64i_immediate_gen immediate_gen0 (
        .instruction (instruction),
        .immediate   (immediate)
    );

    rv64i_datapath datapath0 (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .immediate   (immediate),
        .control     (control),
        .take_branch (take_branch),
        .load_value  (load_value),
        .pc          (instruction_address),
        .alu_result  (alu_result),
        .store_value (store_value),
        .flags       (flags),
        .reg_write   (retired)
    );

    rv64i_memory_interface memory_interface0 (
        .control      (control),
        .address      (alu_result),
        .store_value  (store_value),
        .read_data    (read_data),
        .write_data   (write_data),
        .write_strobe (write_strobe),
        .write_enable (mem_write_enable),
        .load_value   (load_value)
    );

    assign data_address = alu_result;

    // No store or retirement is visible while reset is high
    assign write_enable              = mem_write_enable && !reset;
    assign db_reg_write.enable       = retired.enable && !reset;
    assign db_reg_write.destination  = retired.destination;
    assign db_reg_write.data         = retired.data;

endmodule

/* verification/rv64i_model.svh */
// Reference model state, memory fill pattern, random program generator and instruction model
`ifndef RV64I_MODEL_SVH
`define RV64I_MODEL_SVH

word_t      model_pc;
word_t      model_regs [32];
logic [7:0] model_mem [512];

// Depends on all nine address bits
function automatic logic [7:0] fill_byte(input int address);
    return 8'(address * 29 + 7) ^ {address[8], 7'b0};
endfunction

function automatic word_t sext(input word_t value, input int bits);
    return word_t'($signed(value << (64 - bits)) >>> (64 - bits));
endfunction

task automatic reset_model();
    model_pc = '0;
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
    for (int a = 0; a < 512; a++) begin
        model_mem[a] = fill_byte(a);
    end
endtask

function automatic instr_t random_instruction(input int slot);
    int unsigned kind;
    int unsigned target;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [12:0] branch_offset;
    logic [20:0] jump_offset;
    logic [6:0]  funct7;
    kind   = $urandom % 14;
    rd     = 5'($urandom);
    rs1    = 5'($urandom);
    rs2    = 5'($urandom);
    f3     = 3'($urandom);
    imm    = 12'($urandom);
    funct7 = 7'b0;
    // Forward targets only, every pass reaches the last slot
    target = slot * 4 + 4 * (1 + $urandom % 8);
    if (target > 1020) begin
        target = 1020;
    end
    branch_offset = 13'(target - slot * 4);
    jump_offset   = 21'(target - slot * 4);
    if (slot == 255) begin
        // Back to address 0
        jump_offset = 21'(-1020);
        kind        = 2;
        rd          = 5'd0;
    end
    case (kind)
        0: return {20'($urandom), rd, op_lui};
        1: return {20'($urandom), rd, op_auipc};
        2: return {jump_offset[20], jump_offset[10:1], jump_offset[11],
                   jump_offset[19:12], rd, op_jal};
        // Odd targets exercise the cleared bit 0
        3: return {12'(target | ($urandom & 1)), 5'd0, 3'b000, rd, op_jalr};
        4, 5: begin
            if (f3[2:1] == 2'b01) begin
                f3[2] = 1'b1;
            end
            return {branch_offset[12], branch_offset[10:5], rs2, rs1, f3,
                    branch_offset[4:1], branch_offset[11], op_branch};
        end
        6, 7: begin
            f3  = 3'($urandom % 7);
            imm = 12'((($urandom % 512) >> f3[1:0]) << f3[1:0]);
            return {imm, 5'd0, f3, rd, op_load};
        end
        8, 9: begin
            f3  = 3'($urandom % 4);
            imm = 12'((($urandom % 512) >> f3[1:0]) << f3[1:0]);
            return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};
        end
        10, 11: begin
            if (f3 == 3'b001) begin
                imm = {6'b0, imm[5:0]};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, imm[10], 4'b0, imm[5:0]};
            end
            return {imm, rs1, f3, rd, op_imm};
        end
        12: begin
            if ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) begin
                funct7 = 7'b0100000;
            end
            return {funct7, rs2, rs1, f3, rd, op_reg};
        end
        default: begin
            case ($urandom % 3)
                0: return {imm, rs1, 3'b000, rd, op_imm_32};
                1: return {7'b0000000, rs2, rs1, 3'b000, rd, op_reg_32};
                default: return {7'b0100000, rs2, rs1, 3'b000, rd, op_reg_32};
            endcase
        end
    endcase
endfunction

// Runs one instruction on the model state and returns what the core must show
task automatic execute_instruction(input instr_t instr, output reg_write_t wb,
        output word_t store_address, output word_t store_data, output strobe_t store_strobe);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [4:0] rd;
    logic       taken;
    logic       alternate;
    int         bytes;
    word_t      a;
    word_t      b;
    word_t      operand;
    word_t      imm_i;
    word_t      imm_s;
    word_t      address;
    word_t      result;
    word_t      next_pc;
    opcode        = instr[6:0];
    f3            = instr[14:12];
    rd            = instr[11:7];
    a             = model_regs[instr[19:15]];
    b             = model_regs[instr[24:20]];
    imm_i         = sext(64'(instr[31:20]), 12);
    imm_s         = sext(64'({instr[31:25], instr[11:7]}), 12);
    bytes         = 1 << f3[1:0];
    result        = '0;
    next_pc       = model_pc + 64'd4;
    wb            = '0;
    store_address = '0;
    store_data    = '0;
    store_strobe  = '0;
    case (opcode)
        op_lui:   result = sext(64'({instr[31:12], 12'b0}), 32);
        op_auipc: result = model_pc + sext(64'({instr[31:12], 12'b0}), 32);
        op_jal: begin
            result  = model_pc + 64'd4;
            next_pc = model_pc + sext(64'({instr[31], instr[19:12], instr[20],
                                           instr[30:21], 1'b0}), 21);
        end
        op_jalr: begin
            result  = model_pc + 64'd4;
            next_pc = (a + imm_i) & ~64'd1;
        end
        op_branch: begin
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                default: taken = (a >= b);
            endcase
            if (taken) begin
                next_pc = model_pc + sext(64'({instr[31], instr[7], instr[30:25],
                                               instr[11:8], 1'b0}), 13);
            end
        end
        op_load: begin
            address = a + imm_i;
            for (int k = 0; k < bytes; k++) begin
                result = result | (word_t'(model_mem[int'(address[8:0]) + k]) << (8 * k));
            end
            if (!f3[2]) begin
                result = sext(result, 8 * bytes);
            end
        end
        op_store: begin
            address = a + imm_s;
            for (int k = 0; k < bytes; k++) begin
                model_mem[int'(address[8:0]) + k] = b[8 * k +: 8];
            end
            store_address = address;
            store_data    = b << (8 * address[2:0]);
            store_strobe  = strobe_t'(((1 << bytes) - 1) << address[2:0]);
        end
        op_imm, op_reg: begin
            operand   = (opcode == op_imm) ? imm_i : b;
            alternate = instr[30] && (opcode == op_reg || f3 == 3'b101);
            case (f3)
                3'b000:  result = alternate ? a - operand : a + operand;
                3'b001:  result = a << operand[5:0];
                3'b010:  result = word_t'($signed(a) < $signed(operand));
                3'b011:  result = word_t'(a < operand);
                3'b100:  result = a ^ operand;
                3'b101:  result = alternate ? word_t'($signed(a) >>> operand[5:0])
                                            : a >> operand[5:0];
                3'b110:  result = a | operand;
                default: result = a & operand;
            endcase
        end
        op_imm_32: result = sext(a + imm_i, 32);
        default:   result = sext(instr[30] ? a - b : a + b, 32);
    endcase
    if (opcode != op_branch && opcode != op_store && rd != 5'd0) begin
        model_regs[rd]   = result;
        wb.enable        = 1'b1;
        wb.destination   = rd;
        wb.data          = result;
    end
    model_pc = next_pc;
endtask

`endif

/* verification/rv64i_core_tb.sv */
// Testbench for the RV64I core with memories, random program, model checks and watchdog
`timescale 1ns/1ps

module rv64i_core_tb;
    import rv64i_pkg::*;

    localparam int run_cycles   = 3000;
    localparam int clock_period = 40;
    // Reset cycles and a margin on top of the run
    localparam int watchdog_cycles = run_cycles + 3 + 50;

    logic       clock;
    logic       reset;
    instr_t     instruction;
    word_t      instruction_address;
    word_t      read_data;
    word_t      write_data;
    word_t      data_address;
    strobe_t    write_strobe;
    logic       write_enable;
    reg_write_t db_reg_write;

    instr_t     program_rom [256];
    logic [7:0] data_ram [512];

    `include "rv64i_model.svh"

    rv64i_core dut0 (
        .clock               (clock),
        .reset               (reset),
        .instruction         (instruction),
        .instruction_address (instruction_address),
        .read_data           (read_data),
        .write_data          (write_data),
        .data_address        (data_address),
        .write_strobe        (write_strobe),
        .write_enable        (write_enable),
        .db_reg_write        (db_reg_write)
    );

    always #(clock_period / 2) clock = ~clock;

    // Both memories read combinationally
    assign instruction = program_rom[instruction_address[9:2]];

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            read_data[8 * k +: 8] = data_ram[{data_address[8:3], 3'(k)}];
        end
    end

    always @(posedge clock) begin
        if (write_enable) begin
            for (int k = 0; k < 8; k++) begin
                if (write_strobe[k]) begin
                    data_ram[{data_address[8:3], 3'(k)}] <= write_data[8 * k +: 8];
                end
            end
        end
    end

    task automatic report_mismatch(input string message);
        $display("CHECK FAILED at %0t: %s", $time, message);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_pc(input word_t expected);
        if (instruction_address !== expected) begin
            report_mismatch($sformatf("pc %h, expected %h", instruction_address, expected));
        end
    endtask

    task automatic check_reg_write(input reg_write_t expected);
        if (db_reg_write.enable !== expected.enable || (expected.enable
                && (db_reg_write.destination !== expected.destination
                || db_reg_write.data !== expected.data))) begin
            report_mismatch($sformatf("write-back %b x%0d=%h, expected %b x%0d=%h",
                db_reg_write.enable, db_reg_write.destination, db_reg_write.data,
                expected.enable, expected.destination, expected.data));
        end
    endtask

    task automatic check_store(input word_t address, input word_t data, input strobe_t strobe);
        word_t lanes;
        for (int k = 0; k < 8; k++) begin
            lanes[8 * k +: 8] = {8{strobe[k]}};
        end
        if (write_enable !== (strobe != '0) || write_strobe !== strobe) begin
            report_mismatch($sformatf("store enable %b strobe %b, expected strobe %b",
                write_enable, write_strobe, strobe));
        end else if (strobe != '0 && (data_address !== address
                || (write_data & lanes) !== (data & lanes))) begin
            report_mismatch($sformatf("store %h at %h, expected %h at %h",
                write_data & lanes, data_address, data & lanes, address));
        end
    endtask

    task automatic check_reset_outputs();
        check_pc(reset_pc);
        if (write_enable !== 1'b0 || db_reg_write.enable !== 1'b0) begin
            report_mismatch("store or register write while reset is high");
        end
    endtask

    initial begin
        #(watchdog_cycles * clock_period);
        $display("Watchdog expired, simulation did not finish");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        reg_write_t expected_write;
        word_t      store_address;
        word_t      store_data;
        strobe_t    store_strobe;
        clock = 1'b0;
        reset = 1'b1;
        void'($urandom(93));
        for (int slot = 0; slot < 256; slot++) begin
            program_rom[slot] = random_instruction(slot);
        end
        for (int a = 0; a < 512; a++) begin
            data_ram[a] = fill_byte(a);
        end
        reset_model();
        repeat (2) begin
            @(negedge clock);
            check_reset_outputs();
        end
        @(posedge clock);
        reset <= 1'b0;
        // One instruction retires per cycle, checked mid-cycle
        repeat (run_cycles) begin
            @(negedge clock);
            check_pc(model_pc);
            execute_instruction(program_rom[model_pc[9:2]], expected_write,
                store_address, store_data, store_strobe);
            check_reg_write(expected_write);
            check_store(store_address, store_data, store_strobe);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* files.f */
+incdir+verification
rtl/rv64i_pkg.sv
rtl/rv64i_decoder.sv
rtl/rv64i_immediate_gen.sv
rtl/rv64i_register_file.sv
rtl/rv64i_alu.sv
rtl/rv64i_datapath.sv
rtl/rv64i_memory_interface.sv
rtl/rv64i_core.sv
verification/rv64i_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the RV64I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"

if ! mkdir -p "$build_dir"; then
    echo "Cannot create $build_dir"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module rv64i_core_tb -Mdir "$build_dir/obj_dir" -f files.f; then
    echo "Verilator build failed"
    exit 1
fi

"$build_dir/obj_dir/Vrv64i_core_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TEST FAIL" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "TEST PASS" "$log_file"; then
    echo "Simulation ended without a pass report"
    exit 1
fi

exit 0
